// ==== verilog/mipsDecodePkg.sv ====
`default_nettype none

package mipsDecodePkg;

    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 32;
    localparam int linkReg = 31;

    // instruction field layout
    localparam int opcodeLsb = 26;
    localparam int opcodeWidth = 6;
    localparam int rsLsb = 21;
    localparam int rtLsb = 16;
    localparam int rdLsb = 11;
    localparam int shamtLsb = 6;
    localparam int shamtWidth = 5;
    localparam int functWidth = 6;
    localparam int immWidth = 16;
    localparam int indexWidth = 26;

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;

    typedef enum logic [opcodeWidth-1:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J = 6'h02, OP_JAL = 6'h03,
        OP_BEQ = 6'h04, OP_BNE = 6'h05, OP_BLEZ = 6'h06, OP_BGTZ = 6'h07,
        OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_SLTIU = 6'h0b,
        OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e, OP_LUI = 6'h0f
    } opcode_e;

    typedef enum logic [functWidth-1:0] {
        FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03,
        FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
        FN_JR = 6'h08, FN_JALR = 6'h09,
        FN_ADD = 6'h20, FN_ADDU = 6'h21, FN_SUB = 6'h22, FN_SUBU = 6'h23,
        FN_AND = 6'h24, FN_OR = 6'h25, FN_XOR = 6'h26, FN_NOR = 6'h27,
        FN_SLT = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    // rt codes under REGIMM
    typedef enum logic [regAddrWidth-1:0] {
        RT_BLTZ = 5'h00, RT_BGEZ = 5'h01, RT_BLTZAL = 5'h10, RT_BGEZAL = 5'h11
    } regimm_e;

    // immediate forms reuse the op of the register form
    typedef enum logic [4:0] {
        ALU_NOP, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BGTZ, ALU_BLEZ, ALU_BGEZ, ALU_BLTZ,
        ALU_BGEZAL, ALU_BLTZAL
    } aluOp_e;

    typedef enum logic [2:0] {
        EXE_NOP, EXE_LOGIC, EXE_SHIFT, EXE_ARITH, EXE_JUMP
    } aluSel_e;

endpackage

`default_nettype wire

// ==== verilog/decodeIfs.sv ====
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;
    import mipsDecodePkg::*;

    aluOp_e aluOp;
    aluSel_e aluSel;
    logic read1;
    logic read2;
    regAddr_t raddr1;
    regAddr_t raddr2;
    logic regWe;
    regAddr_t regWaddr;
    word_t immediate;
    // raw branch and jump fields
    logic [immWidth-1:0] offset;
    logic [indexWidth-1:0] index;

    modport producer (
        output aluOp, aluSel, read1, read2, raddr1, raddr2,
        output regWe, regWaddr, immediate, offset, index
    );
    modport consumer (
        input aluOp, aluSel, read1, read2, raddr1, raddr2,
        input regWe, regWaddr, immediate, offset, index
    );
endinterface

interface regReadIf;
    import mipsDecodePkg::*;

    regAddr_t raddr1;
    regAddr_t raddr2;
    word_t rdata1;
    word_t rdata2;

    modport requester (output raddr1, raddr2, input rdata1, rdata2);
    modport responder (input raddr1, raddr2, output rdata1, rdata2);
endinterface

interface bypassIf;
    import mipsDecodePkg::*;

    logic exWe;
    regAddr_t exWaddr;
    word_t exWdata;
    logic memWe;
    regAddr_t memWaddr;
    word_t memWdata;

    modport consumer (input exWe, exWaddr, exWdata, memWe, memWaddr, memWdata);
endinterface

`default_nettype wire

// ==== verilog/instDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instDecoder (
    input mipsDecodePkg::word_t inst,
    decodeIf.producer dec
);
    import mipsDecodePkg::*;

    opcode_e opcode;
    funct_e funct;
    regimm_e rtCode;
    regAddr_t rs;
    regAddr_t rt;
    regAddr_t rd;
    logic [shamtWidth-1:0] shamt;
    logic [immWidth-1:0] imm;
    aluOp_e aluOp;
    aluSel_e aluSel;
    logic specialOp;
    logic constShift;
    logic linking;

    assign opcode = opcode_e'(inst[opcodeLsb +: opcodeWidth]);
    assign funct = funct_e'(inst[functWidth-1:0]);
    assign rs = inst[rsLsb +: regAddrWidth];
    assign rt = inst[rtLsb +: regAddrWidth];
    assign rd = inst[rdLsb +: regAddrWidth];
    assign rtCode = regimm_e'(rt);
    assign shamt = inst[shamtLsb +: shamtWidth];
    assign imm = inst[immWidth-1:0];

    always_comb begin
        aluOp = ALU_NOP;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL, FN_SLLV: aluOp = ALU_SLL;
                    FN_SRL, FN_SRLV: aluOp = ALU_SRL;
                    FN_SRA, FN_SRAV: aluOp = ALU_SRA;
                    FN_JR: aluOp = ALU_JR;
                    FN_JALR: aluOp = ALU_JALR;
                    FN_ADD: aluOp = ALU_ADD;
                    FN_ADDU: aluOp = ALU_ADDU;
                    FN_SUB: aluOp = ALU_SUB;
                    FN_SUBU: aluOp = ALU_SUBU;
                    FN_AND: aluOp = ALU_AND;
                    FN_OR: aluOp = ALU_OR;
                    FN_XOR: aluOp = ALU_XOR;
                    FN_NOR: aluOp = ALU_NOR;
                    FN_SLT: aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    default: aluOp = ALU_NOP;
                endcase
            end
            OP_REGIMM: begin
                case (rtCode)
                    RT_BLTZ: aluOp = ALU_BLTZ;
                    RT_BGEZ: aluOp = ALU_BGEZ;
                    RT_BLTZAL: aluOp = ALU_BLTZAL;
                    RT_BGEZAL: aluOp = ALU_BGEZAL;
                    default: aluOp = ALU_NOP;
                endcase
            end
            OP_J: aluOp = ALU_J;
            OP_JAL: aluOp = ALU_JAL;
            OP_BEQ: aluOp = ALU_BEQ;
            OP_BNE: aluOp = ALU_BNE;
            OP_BLEZ: aluOp = ALU_BLEZ;
            OP_BGTZ: aluOp = ALU_BGTZ;
            OP_ADDI: aluOp = ALU_ADD;
            OP_ADDIU: aluOp = ALU_ADDU;
            OP_SLTI: aluOp = ALU_SLT;
            OP_SLTIU: aluOp = ALU_SLTU;
            OP_ANDI: aluOp = ALU_AND;
            // lui is an or of the shifted immediate with $0
            OP_ORI, OP_LUI: aluOp = ALU_OR;
            OP_XORI: aluOp = ALU_XOR;
            default: aluOp = ALU_NOP;
        endcase
    end

    always_comb begin
        case (aluOp)
            ALU_NOP: aluSel = EXE_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: aluSel = EXE_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA: aluSel = EXE_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU: aluSel = EXE_ARITH;
            default: aluSel = EXE_JUMP;
        endcase
    end

    assign specialOp = (opcode == OP_SPECIAL);
    assign constShift = specialOp && (funct inside {FN_SLL, FN_SRL, FN_SRA});
    assign linking = aluOp inside {ALU_JAL, ALU_BGEZAL, ALU_BLTZAL};

    // shift amount, zero-extended logic, sign-extended arithmetic, lui upper half
    always_comb begin
        case (opcode)
            OP_SPECIAL: dec.immediate = constShift ? word_t'(shamt) : '0;
            OP_ANDI, OP_ORI, OP_XORI: dec.immediate = {{(dataWidth-immWidth){1'b0}}, imm};
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU:
                dec.immediate = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};
            OP_LUI: dec.immediate = {imm, {(dataWidth-immWidth){1'b0}}};
            default: dec.immediate = '0;
        endcase
    end

    assign dec.aluOp = aluOp;
    assign dec.aluSel = aluSel;
    assign dec.read1 = !(aluOp inside {ALU_NOP, ALU_J, ALU_JAL}) && !constShift;
    assign dec.read2 = (specialOp && !(aluOp inside {ALU_NOP, ALU_JR, ALU_JALR}))
                       || (aluOp inside {ALU_BEQ, ALU_BNE});
    assign dec.regWe = (aluSel inside {EXE_LOGIC, EXE_SHIFT, EXE_ARITH})
                       || linking || (aluOp == ALU_JALR);
    assign dec.regWaddr = linking ? regAddr_t'(linkReg) : (specialOp ? rd : rt);
    assign dec.raddr1 = rs;
    assign dec.raddr2 = rt;
    assign dec.offset = imm;
    assign dec.index = inst[indexWidth-1:0];

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input logic clk,
    input logic rst,
    input logic wbWe,
    input mipsDecodePkg::regAddr_t wbWaddr,
    input mipsDecodePkg::word_t wbWdata,
    regReadIf.responder rd
);
    import mipsDecodePkg::*;

    word_t regs [regCount];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wbWe && (wbWaddr != '0)) begin
            regs[wbWaddr] <= wbWdata;
        end
    end

    // $0 reads zero, WB data passes straight through
    function automatic word_t readPort(regAddr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wbWe && (addr == wbWaddr)) begin
            return wbWdata;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd.rdata1 = readPort(rd.raddr1);
        rd.rdata2 = readPort(rd.raddr2);
    end

endmodule

`default_nettype wire

// ==== verilog/operandSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandSelect (
    decodeIf.consumer dec,
    regReadIf.requester rf,
    bypassIf.consumer byp,
    output mipsDecodePkg::word_t operandA,
    output mipsDecodePkg::word_t operandB
);
    import mipsDecodePkg::*;

    assign rf.raddr1 = dec.raddr1;
    assign rf.raddr2 = dec.raddr2;

    // EX before MEM before the register file
    function automatic word_t forward(logic readEn, regAddr_t addr, word_t rfData);
        if (!readEn) begin
            return dec.immediate;
        end
        if (byp.exWe && (byp.exWaddr == addr)) begin
            return byp.exWdata;
        end
        if (byp.memWe && (byp.memWaddr == addr)) begin
            return byp.memWdata;
        end
        return rfData;
    endfunction

    always_comb begin
        operandA = forward(dec.read1, dec.raddr1, rf.rdata1);
        operandB = forward(dec.read2, dec.raddr2, rf.rdata2);
    end

endmodule

`default_nettype wire

// ==== verilog/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnit (
    input mipsDecodePkg::word_t pc,
    decodeIf.consumer dec,
    input mipsDecodePkg::word_t operandA,
    input mipsDecodePkg::word_t operandB,
    output logic branchTaken,
    output mipsDecodePkg::word_t branchTarget,
    output mipsDecodePkg::word_t linkAddr
);
    import mipsDecodePkg::*;

    word_t pcPlus4;
    word_t pcPlus8;
    word_t branchDest;
    word_t jumpDest;
    word_t dest;
    logic condMet;

    assign pcPlus4 = pc + word_t'(4);
    assign pcPlus8 = pc + word_t'(8);
    assign branchDest = pcPlus4
                        + {{(dataWidth-immWidth-2){dec.offset[immWidth-1]}}, dec.offset, 2'b00};
    // region of the delay slot, not of the jump
    assign jumpDest = {pcPlus4[dataWidth-1 -: 4], dec.index, 2'b00};

    always_comb begin
        case (dec.aluOp)
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR: condMet = 1'b1;
            ALU_BEQ: condMet = (operandA == operandB);
            ALU_BNE: condMet = (operandA != operandB);
            ALU_BGTZ: condMet = !operandA[dataWidth-1] && (operandA != '0);
            ALU_BLEZ: condMet = operandA[dataWidth-1] || (operandA == '0);
            ALU_BGEZ, ALU_BGEZAL: condMet = !operandA[dataWidth-1];
            ALU_BLTZ, ALU_BLTZAL: condMet = operandA[dataWidth-1];
            default: condMet = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.aluOp)
            ALU_J, ALU_JAL: dest = jumpDest;
            ALU_JR, ALU_JALR: dest = operandA;
            default: dest = branchDest;
        endcase
    end

    assign branchTaken = condMet;
    assign branchTarget = condMet ? dest : '0;
    assign linkAddr = (dec.aluOp inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL})
                      ? pcPlus8 : '0;

endmodule

`default_nettype wire

// ==== verilog/issueHandshake.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueHandshake (
    input logic clk,
    input logic rst,
    input logic req,
    decodeIf.consumer dec,
    input mipsDecodePkg::word_t operandA,
    input mipsDecodePkg::word_t operandB,
    input logic branchTaken,
    input mipsDecodePkg::word_t branchTarget,
    input mipsDecodePkg::word_t linkAddr,
    output logic ack,
    output mipsDecodePkg::aluOp_e aluOp,
    output mipsDecodePkg::aluSel_e aluSel,
    output mipsDecodePkg::word_t heldOperandA,
    output mipsDecodePkg::word_t heldOperandB,
    output logic regWe,
    output mipsDecodePkg::regAddr_t regWaddr,
    output mipsDecodePkg::word_t heldLinkAddr,
    output mipsDecodePkg::word_t heldBranchTarget,
    output logic heldBranchTaken,
    output logic inSlot
);
    import mipsDecodePkg::*;

    typedef enum logic {
        IDLE,
        HOLD
    } state_e;

    state_e state;

    assign ack = (state == HOLD);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            aluOp <= ALU_NOP;
            aluSel <= EXE_NOP;
            heldOperandA <= '0;
            heldOperandB <= '0;
            regWe <= 1'b0;
            regWaddr <= '0;
            heldLinkAddr <= '0;
            heldBranchTarget <= '0;
            heldBranchTaken <= 1'b0;
            inSlot <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        state <= HOLD;
                        aluOp <= dec.aluOp;
                        aluSel <= dec.aluSel;
                        heldOperandA <= operandA;
                        heldOperandB <= operandB;
                        regWe <= dec.regWe;
                        regWaddr <= dec.regWaddr;
                        heldLinkAddr <= linkAddr;
                        heldBranchTarget <= branchTarget;
                        heldBranchTaken <= branchTaken;
                        // previous instruction still held here
                        inSlot <= heldBranchTaken;
                    end
                end
                HOLD: begin
                    if (!req) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/idStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStage (
    input logic clk,
    input logic rst,
    input logic req,
    input mipsDecodePkg::word_t pc,
    input mipsDecodePkg::word_t inst,
    input logic exWe,
    input mipsDecodePkg::regAddr_t exWaddr,
    input mipsDecodePkg::word_t exWdata,
    input logic memWe,
    input mipsDecodePkg::regAddr_t memWaddr,
    input mipsDecodePkg::word_t memWdata,
    input logic wbWe,
    input mipsDecodePkg::regAddr_t wbWaddr,
    input mipsDecodePkg::word_t wbWdata,
    output logic ack,
    output mipsDecodePkg::aluOp_e aluOp,
    output mipsDecodePkg::aluSel_e aluSel,
    output mipsDecodePkg::word_t operandA,
    output mipsDecodePkg::word_t operandB,
    output logic regWe,
    output mipsDecodePkg::regAddr_t regWaddr,
    output mipsDecodePkg::word_t linkAddr,
    output mipsDecodePkg::word_t branchTarget,
    output logic branchTaken,
    output logic inSlot
);
    import mipsDecodePkg::*;

    decodeIf dec ();
    regReadIf rdPort ();
    bypassIf byp ();

    // combinational results ahead of the output registers
    word_t srcA;
    word_t srcB;
    logic nextTaken;
    word_t nextTarget;
    word_t nextLink;

    assign byp.exWe = exWe;
    assign byp.exWaddr = exWaddr;
    assign byp.exWdata = exWdata;
    assign byp.memWe = memWe;
    assign byp.memWaddr = memWaddr;
    assign byp.memWdata = memWdata;

    instDecoder uDecoder (
        .inst(inst),
        .dec(dec.producer)
    );

    regFile uRegFile (
        .clk(clk),
        .rst(rst),
        .wbWe(wbWe),
        .wbWaddr(wbWaddr),
        .wbWdata(wbWdata),
        .rd(rdPort.responder)
    );

    operandSelect uOperands (
        .dec(dec.consumer),
        .rf(rdPort.requester),
        .byp(byp.consumer),
        .operandA(srcA),
        .operandB(srcB)
    );

    branchUnit uBranch (
        .pc(pc),
        .dec(dec.consumer),
        .operandA(srcA),
        .operandB(srcB),
        .branchTaken(nextTaken),
        .branchTarget(nextTarget),
        .linkAddr(nextLink)
    );

    issueHandshake uIssue (
        .clk(clk),
        .rst(rst),
        .req(req),
        .dec(dec.consumer),
        .operandA(srcA),
        .operandB(srcB),
        .branchTaken(nextTaken),
        .branchTarget(nextTarget),
        .linkAddr(nextLink),
        .ack(ack),
        .aluOp(aluOp),
        .aluSel(aluSel),
        .heldOperandA(operandA),
        .heldOperandB(operandB),
        .regWe(regWe),
        .regWaddr(regWaddr),
        .heldLinkAddr(linkAddr),
        .heldBranchTarget(branchTarget),
        .heldBranchTaken(branchTaken),
        .inSlot(inSlot)
    );

endmodule

`default_nettype wire

// ==== verification/idStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module idStageTb;
    import mipsDecodePkg::*;

    typedef struct packed {
        logic exWe;
        regAddr_t exAddr;
        word_t exData;
        logic memWe;
        regAddr_t memAddr;
        word_t memData;
    } bypass_t;

    typedef struct packed {
        aluOp_e aluOp;
        aluSel_e aluSel;
        word_t opA;
        word_t opB;
        logic we;
        regAddr_t waddr;
        word_t link;
        word_t target;
        logic taken;
        logic slot;
    } expect_t;

    logic clk, rst, req, exWe, memWe, wbWe;
    word_t pc, inst, exWdata, memWdata, wbWdata;
    regAddr_t exWaddr, memWaddr, wbWaddr;
    logic ack, regWe, branchTaken, inSlot;
    aluOp_e aluOp;
    aluSel_e aluSel;
    word_t operandA, operandB, linkAddr, branchTarget;
    regAddr_t regWaddr;

    word_t modelRegs [regCount];
    logic [31:0] lfsrState = 32'h5df33e2a;
    expect_t expected;
    logic pending = 1'b0;
    logic prevTaken = 1'b0;
    int errors = 0, checks = 0, testsRun = 0, testsFailed = 0, testStartErrors = 0;
    int riseWait, fallWait;

    idStage uut (
        .clk(clk), .rst(rst), .req(req), .pc(pc), .inst(inst),
        .exWe(exWe), .exWaddr(exWaddr), .exWdata(exWdata),
        .memWe(memWe), .memWaddr(memWaddr), .memWdata(memWdata),
        .wbWe(wbWe), .wbWaddr(wbWaddr), .wbWdata(wbWdata),
        .ack(ack), .aluOp(aluOp), .aluSel(aluSel), .operandA(operandA),
        .operandB(operandB), .regWe(regWe), .regWaddr(regWaddr), .linkAddr(linkAddr),
        .branchTarget(branchTarget), .branchTaken(branchTaken), .inSlot(inSlot)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsrState[0]};
            lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
        end
        return r;
    endfunction

    function automatic regAddr_t drawReg();
        return regAddr_t'(randBits(5));
    endfunction

    function automatic word_t rType(regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    logic [4:0] sh, logic [5:0] fn);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(logic [5:0] op, regAddr_t rs, regAddr_t rt,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t pickOperand(logic rdEn, regAddr_t a, word_t immv, bypass_t bp);
        if (!rdEn) return immv;
        if (bp.exWe && bp.exAddr == a) return bp.exData;
        if (bp.memWe && bp.memAddr == a) return bp.memData;
        return (a == 0) ? '0 : modelRegs[a];
    endfunction

    // expected outputs straight from the MIPS encoding rules
    function automatic expect_t refDecode(word_t p, word_t ins, bypass_t bp, logic prev);
        expect_t e;
        logic [5:0] op, fn;
        regAddr_t rs, rt, rd;
        logic [15:0] imm;
        logic constShift, link, r1, r2, cond;
        word_t immv, dest;
        op = ins[31:26];
        fn = ins[5:0];
        rs = ins[25:21];
        rt = ins[20:16];
        rd = ins[15:11];
        imm = ins[15:0];
        e = '0;
        e.aluOp = ALU_NOP;
        case (op)
            6'h00: case (fn)
                6'h00, 6'h04: e.aluOp = ALU_SLL;
                6'h02, 6'h06: e.aluOp = ALU_SRL;
                6'h03, 6'h07: e.aluOp = ALU_SRA;
                6'h08: e.aluOp = ALU_JR;
                6'h09: e.aluOp = ALU_JALR;
                6'h20: e.aluOp = ALU_ADD;
                6'h21: e.aluOp = ALU_ADDU;
                6'h22: e.aluOp = ALU_SUB;
                6'h23: e.aluOp = ALU_SUBU;
                6'h24: e.aluOp = ALU_AND;
                6'h25: e.aluOp = ALU_OR;
                6'h26: e.aluOp = ALU_XOR;
                6'h27: e.aluOp = ALU_NOR;
                6'h2a: e.aluOp = ALU_SLT;
                6'h2b: e.aluOp = ALU_SLTU;
                default: e.aluOp = ALU_NOP;
            endcase
            6'h01: case (rt)
                5'h00: e.aluOp = ALU_BLTZ;
                5'h01: e.aluOp = ALU_BGEZ;
                5'h10: e.aluOp = ALU_BLTZAL;
                5'h11: e.aluOp = ALU_BGEZAL;
                default: e.aluOp = ALU_NOP;
            endcase
            6'h02: e.aluOp = ALU_J;
            6'h03: e.aluOp = ALU_JAL;
            6'h04: e.aluOp = ALU_BEQ;
            6'h05: e.aluOp = ALU_BNE;
            6'h06: e.aluOp = ALU_BLEZ;
            6'h07: e.aluOp = ALU_BGTZ;
            6'h08: e.aluOp = ALU_ADD;
            6'h09: e.aluOp = ALU_ADDU;
            6'h0a: e.aluOp = ALU_SLT;
            6'h0b: e.aluOp = ALU_SLTU;
            6'h0c: e.aluOp = ALU_AND;
            6'h0d, 6'h0f: e.aluOp = ALU_OR;
            6'h0e: e.aluOp = ALU_XOR;
            default: e.aluOp = ALU_NOP;
        endcase
        case (e.aluOp)
            ALU_NOP: e.aluSel = EXE_NOP;
            ALU_AND, ALU_OR, ALU_XOR, ALU_NOR: e.aluSel = EXE_LOGIC;
            ALU_SLL, ALU_SRL, ALU_SRA: e.aluSel = EXE_SHIFT;
            ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU: e.aluSel = EXE_ARITH;
            default: e.aluSel = EXE_JUMP;
        endcase
        constShift = (op == 6'h00) && (fn == 6'h00 || fn == 6'h02 || fn == 6'h03);
        link = e.aluOp inside {ALU_JAL, ALU_BGEZAL, ALU_BLTZAL};
        case (op)
            6'h00: immv = constShift ? {27'b0, ins[10:6]} : '0;
            6'h0c, 6'h0d, 6'h0e: immv = {16'b0, imm};
            6'h08, 6'h09, 6'h0a, 6'h0b: immv = {{16{imm[15]}}, imm};
            6'h0f: immv = {imm, 16'b0};
            default: immv = '0;
        endcase
        r1 = !(e.aluOp inside {ALU_NOP, ALU_J, ALU_JAL}) && !constShift;
        r2 = ((op == 6'h00) && !(e.aluOp inside {ALU_NOP, ALU_JR, ALU_JALR}))
             || (e.aluOp inside {ALU_BEQ, ALU_BNE});
        e.opA = pickOperand(r1, rs, immv, bp);
        e.opB = pickOperand(r2, rt, immv, bp);
        e.we = (e.aluSel inside {EXE_LOGIC, EXE_SHIFT, EXE_ARITH}) || link
               || e.aluOp == ALU_JALR;
        e.waddr = link ? 5'd31 : ((op == 6'h00) ? rd : rt);
        case (e.aluOp)
            ALU_J, ALU_JAL, ALU_JR, ALU_JALR: cond = 1'b1;
            ALU_BEQ: cond = e.opA == e.opB;
            ALU_BNE: cond = e.opA != e.opB;
            ALU_BGTZ: cond = $signed(e.opA) > 0;
            ALU_BLEZ: cond = $signed(e.opA) <= 0;
            ALU_BGEZ, ALU_BGEZAL: cond = $signed(e.opA) >= 0;
            ALU_BLTZ, ALU_BLTZAL: cond = $signed(e.opA) < 0;
            default: cond = 1'b0;
        endcase
        if (e.aluOp inside {ALU_J, ALU_JAL}) begin
            dest = {p[31:28] + 4'(p[27:2] == '1), ins[25:0], 2'b00};
        end else if (e.aluOp inside {ALU_JR, ALU_JALR}) begin
            dest = e.opA;
        end else begin
            dest = p + 4 + ({{16{imm[15]}}, imm} << 2);
        end
        e.taken = cond;
        e.target = cond ? dest : '0;
        e.link = (link || e.aluOp == ALU_JALR) ? p + 8 : '0;
        e.slot = prev;
        return e;
    endfunction

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareAll(expect_t e);
        check("aluOp", 32'(aluOp), 32'(e.aluOp));
        check("aluSel", 32'(aluSel), 32'(e.aluSel));
        check("operandA", operandA, e.opA);
        check("operandB", operandB, e.opB);
        check("regWe", 32'(regWe), 32'(e.we));
        check("regWaddr", 32'(regWaddr), 32'(e.waddr));
        check("linkAddr", linkAddr, e.link);
        check("branchTarget", branchTarget, e.target);
        check("branchTaken", 32'(branchTaken), 32'(e.taken));
        check("inSlot", 32'(inSlot), 32'(e.slot));
    endtask

    task automatic abortRun(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $finish;
    endtask

    // one compare per completed handshake
    always @(negedge clk) begin
        if (pending && ack) begin
            compareAll(expected);
            pending = 1'b0;
        end
    end

    task automatic writeReg(regAddr_t a, word_t d);
        @(posedge clk);
        wbWe <= 1'b1;
        wbWaddr <= a;
        wbWdata <= d;
        if (a != 0) modelRegs[a] = d;
    endtask

    task automatic issue(word_t p, word_t ins, bypass_t bp, logic we, regAddr_t wa, word_t wd,
                         int hold);
        int n;
        @(posedge clk);
        req <= 1'b1;
        pc <= p;
        inst <= ins;
        {exWe, exWaddr, exWdata, memWe, memWaddr, memWdata} <= bp;
        wbWe <= we;
        wbWaddr <= wa;
        wbWdata <= wd;
        // wb write lands on the accepting edge and is read through
        if (we && wa != 0) modelRegs[wa] = wd;
        expected = refDecode(p, ins, bp, prevTaken);
        prevTaken = expected.taken;
        pending = 1'b1;
        n = 0;
        @(negedge clk);
        while (!ack) begin
            n++;
            if (n > 20) abortRun("timeout waiting for ack to rise");
            @(negedge clk);
        end
        riseWait = n;
        repeat (hold) begin
            @(posedge clk);
            wbWe <= 1'b0;
            // requester may move on once ack is high
            inst <= ~ins;
            @(negedge clk);
            check("ack", 32'(ack), 32'd1);
            compareAll(expected);
        end
        @(posedge clk);
        req <= 1'b0;
        wbWe <= 1'b0;
        exWe <= 1'b0;
        memWe <= 1'b0;
        n = 0;
        @(negedge clk);
        while (ack) begin
            n++;
            if (n > 20) abortRun("timeout waiting for ack to fall");
            @(negedge clk);
        end
        fallWait = n;
    endtask

    task automatic endTest(string name);
        testsRun++;
        if (errors != testStartErrors) testsFailed++;
        $display("test %0d %s: %0d errors", testsRun, name, errors - testStartErrors);
        testStartErrors = errors;
    endtask

    task automatic preload();
        for (int r = 1; r < regCount; r++) begin
            writeReg(regAddr_t'(r), randBits(32));
        end
        writeReg(5'd7, '0);
        @(posedge clk);
        wbWe <= 1'b0;
    endtask

    initial begin
        bypass_t noBp;
        bypass_t bp;
        logic [5:0] fnSet [12];
        logic [5:0] opSet [4];
        word_t ins;
        int k;
        noBp = '0;
        fnSet = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
                  6'h20, 6'h21, 6'h22, 6'h23, 6'h2a, 6'h2b};
        opSet = '{6'h08, 6'h09, 6'h0a, 6'h0b};
        rst = 1'b1;
        {req, exWe, memWe, wbWe} = '0;
        {pc, inst, exWdata, memWdata, wbWdata} = '0;
        {exWaddr, memWaddr, wbWaddr} = '0;
        for (int r = 0; r < regCount; r++) modelRegs[r] = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        compareAll(expect_t'{ALU_NOP, EXE_NOP, '0, '0, 1'b0, '0, '0, '0, 1'b0, 1'b0});
        check("ack", 32'(ack), 32'd0);
        issue(32'h100, rType(5'd0, 5'd0, 5'd3, 5'd0, 6'h21), noBp, 1'b0, '0, '0, 4);
        check("ackRiseCycles", riseWait, 32'd1);
        check("ackFallCycles", fallWait, 32'd1);
        issue(32'h104, 32'hfc12_3456, noBp, 1'b0, '0, '0, 0);
        check("aluOp", 32'(aluOp), 32'(ALU_NOP));
        endTest("reset and handshake");

        preload();
        for (int i = 0; i < 24; i++) begin
            k = randBits(3);
            if (k < 4) ins = rType(drawReg(), drawReg(), drawReg(), 5'd0, 6'h24 + 6'(k));
            else ins = iType(6'h0c + 6'(k - 4), drawReg(), drawReg(), 16'(randBits(16)));
            issue(randBits(30) << 2, ins, noBp, 1'b0, '0, '0, 0);
        end
        endTest("logic and immediates");

        for (int i = 0; i < 40; i++) begin
            k = randBits(4);
            if (k < 12) ins = rType(drawReg(), drawReg(), drawReg(), 5'(randBits(5)), fnSet[k]);
            else ins = iType(opSet[k - 12], drawReg(), drawReg(), {1'b1, 15'(randBits(15))});
            issue(randBits(30) << 2, ins, noBp, 1'b0, '0, '0, 0);
        end
        endTest("shifts and arithmetic");

        for (int i = 0; i < 30; i++) begin
            regAddr_t rs, rt;
            rs = drawReg();
            rt = drawReg();
            bp.exWe = 1'(randBits(1));
            bp.exAddr = randBits(1) ? rs : rt;
            bp.exData = randBits(32);
            bp.memWe = 1'(randBits(1));
            bp.memAddr = randBits(1) ? rs : rt;
            bp.memData = randBits(32);
            issue(randBits(30) << 2, rType(rs, rt, drawReg(), 5'd0, 6'h21), bp,
                  1'(randBits(1)), randBits(1) ? rs : rt, randBits(32), 0);
        end
        endTest("forwarding priority");

        for (int i = 0; i < 40; i++) begin
            regAddr_t rs, rt;
            rs = drawReg();
            rt = randBits(1) ? rs : 5'(randBits(5));
            k = randBits(4) % 12;
            case (k)
                0: ins = iType(6'h04, rs, rt, 16'(randBits(16)));
                1: ins = iType(6'h05, rs, rt, 16'(randBits(16)));
                2: ins = iType(6'h06, rs, 5'd0, 16'(randBits(16)));
                3: ins = iType(6'h07, rs, 5'd0, 16'(randBits(16)));
                4: ins = iType(6'h01, rs, 5'h00, 16'(randBits(16)));
                5: ins = iType(6'h01, rs, 5'h01, 16'(randBits(16)));
                6: ins = iType(6'h01, rs, 5'h10, 16'(randBits(16)));
                7: ins = iType(6'h01, rs, 5'h11, 16'(randBits(16)));
                8: ins = {6'h02, 26'(randBits(26))};
                9: ins = {6'h03, 26'(randBits(26))};
                10: ins = rType(rs, 5'd0, 5'd0, 5'd0, 6'h08);
                default: ins = rType(rs, 5'd0, drawReg(), 5'd0, 6'h09);
            endcase
            issue(randBits(30) << 2, ins, noBp, 1'b0, '0, '0, 0);
        end
        endTest("branches and jumps");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== idStage.f ====
verilog/mipsDecodePkg.sv
verilog/decodeIfs.sv
verilog/instDecoder.sv
verilog/regFile.sv
verilog/operandSelect.sv
verilog/branchUnit.sv
verilog/issueHandshake.sv
verilog/idStage.sv
verification/idStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --timing -j 0
TOP := idStageTb
FILELIST := idStage.f
OBJDIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
